//--- common/note_pkg.sv
// Shared definitions for the note detection back end
// Note count, score and threshold widths, threshold defaults, button
// debounce length, serial bit timing and the types passed between the
// input side, the detector bank and the serializer
package note_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////
    localparam int NUM_NOTES  = 48;  // Notes tracked by the bank
    localparam int NOTE_SEL_W = 6;   // Wide enough for 0..47
    localparam int CORR_W     = 10;  // Score and threshold width

    // Threshold defaults, one pair shared by every note
    localparam logic [CORR_W-1:0] THRESH_HIGH_DEFAULT = 10'h19A;
    localparam logic [CORR_W-1:0] THRESH_LOW_DEFAULT  = 10'h0FE;
    localparam int                THRESH_STEP         = 2;  // Per press

    localparam int DEBOUNCE_DEFAULT = 650000;  // About 10 ms at 65 MHz
    localparam int BIT_CYCLES       = 8;       // Clocks per serial bit

    //////////////////////////////
    // Types
    //////////////////////////////
    typedef logic [NOTE_SEL_W-1:0] note_idx_t;     // Note number
    typedef logic [CORR_W-1:0]     correlation_t;  // Score or threshold

    // All scores in one vector, note 0 in the lowest slice
    typedef correlation_t [NUM_NOTES-1:0] corr_vec_t;

    typedef logic [NUM_NOTES-1:0] active_vec_t;  // One flag per note

    // Front panel state after synchronizing and debouncing
    typedef struct packed {
        note_idx_t note_sel;    // Note being tuned
        logic      thresh_sel;  // 1 tunes high, 0 tunes low
        logic      inc;         // One cycle pulse per up press
        logic      dec;         // One cycle pulse per down press
    } panel_ctrl_t;

    typedef struct packed {
        correlation_t high;  // Turn on at or above
        correlation_t low;   // Turn off below
    } thresh_pair_t;

    // Serial frame phases
    typedef enum logic {
        SER_SYNC,  // Sync period, data low
        SER_DATA   // One active bit per period
    } ser_state_t;

endpackage

//--- hdl/button_conditioner.sv
// Push button conditioner
// Two flop synchronizer, then a stability counter that only moves the
// clean level after the input has held a new value long enough.
// A rising clean level gives a single cycle press pulse
module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 650000  // Stable cycles needed
) (
    input  logic clk_65mhz,
    input  logic rst,
    input  logic btn,    // Raw, asynchronous, bouncy
    output logic pulse   // One cycle per debounced press
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic [1:0]       btn_sync;  // [1] is the synchronized level
    logic [CNT_W-1:0] stable_cnt;
    logic             clean;
    logic             clean_q;   // Clean level one cycle back

    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            btn_sync   <= '0;
            stable_cnt <= '0;
            clean      <= 1'b0;
            clean_q    <= 1'b0;
        end else begin
            btn_sync <= {btn_sync[0], btn};
            clean_q  <= clean;

            // Count consecutive cycles at a level different from clean
            if (btn_sync[1] != clean) begin
                if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    clean      <= btn_sync[1];  // Held long enough
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                stable_cnt <= '0;  // Bounced back, start over
            end
        end
    end

    // Press edge only, releases give nothing
    assign pulse = clean & ~clean_q;

endmodule

//--- hdl/panel_input.sv
// Front panel input side
// Conditions the up and down buttons into press pulses and double
// registers the note and threshold select switches, then packs them
// into one control struct for the detector bank
module panel_input
    import note_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = DEBOUNCE_DEFAULT
) (
    input  logic        clk_65mhz,
    input  logic        rst,
    input  logic        btn_up,         // Raw up button
    input  logic        btn_down,       // Raw down button
    input  note_idx_t   sw_note,        // Raw note select switches
    input  logic        sw_thresh_sel,  // Raw high/low select switch
    output panel_ctrl_t ctrl
);

    logic      up_pulse;
    logic      down_pulse;
    note_idx_t note_meta, note_sync;  // Switch synchronizer stages
    logic      sel_meta, sel_sync;

    //////////////////////////////
    // Buttons
    button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_btn_up (
        .clk_65mhz (clk_65mhz),
        .rst       (rst),
        .btn       (btn_up),
        .pulse     (up_pulse)
    );

    button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_btn_down (
        .clk_65mhz (clk_65mhz),
        .rst       (rst),
        .btn       (btn_down),
        .pulse     (down_pulse)
    );

    //////////////////////////////
    // Switches, seen two cycles after they move
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            note_meta <= '0;
            note_sync <= '0;
            sel_meta  <= 1'b0;
            sel_sync  <= 1'b0;
        end else begin
            note_meta <= sw_note;
            note_sync <= note_meta;
            sel_meta  <= sw_thresh_sel;
            sel_sync  <= sel_meta;
        end
    end

    // Out of range notes pass as is, the bank drops them
    assign ctrl = '{note_sel: note_sync, thresh_sel: sel_sync,
                    inc: up_pulse, dec: down_pulse};

endmodule

//--- detect/note_threshold.sv
// Single note detector
// Holds an adjustable high/low threshold pair and the note's active
// flag. Press pulses step the chosen threshold by a fixed amount with
// saturation at both ends. On each score strobe the flag follows a
// hysteresis rule, on at or above high and off below low
module note_threshold
    import note_pkg::*;
(
    input  logic         clk_65mhz,
    input  logic         rst,
    input  correlation_t correlation,        // This note's score
    input  logic         correlation_valid,  // Score strobe
    input  logic         thresh_sel,         // 1 steps high, 0 steps low
    input  logic         inc,                // Step up pulse
    input  logic         dec,                // Step down pulse
    output thresh_pair_t thresholds,
    output logic         active
);

    correlation_t thresh_high;
    correlation_t thresh_low;
    correlation_t stepped;  // Selected threshold after this cycle's step

    // Saturating step, the extra top bit catches wrap in either direction
    function automatic correlation_t sat_step(input correlation_t value,
                                              input logic         up);
        logic [CORR_W:0] sum;
        if (up) begin
            sum = {1'b0, value} + (CORR_W + 1)'(THRESH_STEP);
            sat_step = sum[CORR_W] ? '1 : sum[CORR_W-1:0];  // Cap at 1023
        end else begin
            sum = {1'b0, value} - (CORR_W + 1)'(THRESH_STEP);
            sat_step = sum[CORR_W] ? '0 : sum[CORR_W-1:0];  // Floor at 0
        end
    endfunction

    assign stepped = sat_step(thresh_sel ? thresh_high : thresh_low, inc);

    //////////////////////////////
    // Threshold registers
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            thresh_high <= THRESH_HIGH_DEFAULT;
            thresh_low  <= THRESH_LOW_DEFAULT;
        end else if (inc || dec) begin
            // Pair order is not enforced, the player may cross them
            if (thresh_sel) begin
                thresh_high <= stepped;
            end else begin
                thresh_low <= stepped;
            end
        end
    end

    //////////////////////////////
    // Hysteresis
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            active <= 1'b0;
        end else if (correlation_valid) begin
            if (correlation >= thresh_high) begin
                active <= 1'b1;                    // Strong match
            end else if (correlation < thresh_low) begin
                active <= 1'b0;                    // Dropped away
            end
            // In between, keep the previous decision
        end
    end

    assign thresholds = '{high: thresh_high, low: thresh_low};  // Readout

endmodule

//--- detect/note_detector_bank.sv
// Note detector bank
// One threshold detector per note. The panel's press pulses go only to
// the selected note, and that note's threshold pair is muxed out for the
// readout. A select of 48 or above reaches no note and reads as zero
module note_detector_bank
    import note_pkg::*;
(
    input  logic         clk_65mhz,
    input  logic         rst,
    input  panel_ctrl_t  ctrl,                // Select and press pulses
    input  corr_vec_t    correlations,        // All notes' scores
    input  logic         correlations_valid,  // Strobe for the whole vector
    output active_vec_t  active,
    output thresh_pair_t sel_thresh
);

    logic [NUM_NOTES-1:0] inc_vec;   // Per note step up strobes
    logic [NUM_NOTES-1:0] dec_vec;   // Per note step down strobes
    thresh_pair_t         pairs [NUM_NOTES];
    logic                 sel_in_range;

    //////////////////////////////
    // Detectors
    for (genvar n = 0; n < NUM_NOTES; n++) begin : g_note
        // Steer the pulses, indexes 48..63 never match
        assign inc_vec[n] = ctrl.inc && (ctrl.note_sel == note_idx_t'(n));
        assign dec_vec[n] = ctrl.dec && (ctrl.note_sel == note_idx_t'(n));

        note_threshold i_note_threshold (
            .clk_65mhz         (clk_65mhz),
            .rst               (rst),
            .correlation       (correlations[n]),
            .correlation_valid (correlations_valid),
            .thresh_sel        (ctrl.thresh_sel),
            .inc               (inc_vec[n]),
            .dec               (dec_vec[n]),
            .thresholds        (pairs[n]),
            .active            (active[n])
        );
    end

    //////////////////////////////
    // Readout mux
    assign sel_in_range = (ctrl.note_sel < NUM_NOTES);

    always_comb begin
        sel_thresh = '0;  // Nothing to show for an unused index
        if (sel_in_range) begin
            sel_thresh = pairs[ctrl.note_sel];
        end
    end

endmodule

//--- hdl/note_serializer.sv
// Active note serializer
// Sends the 48 active flags on two pins in back to back frames of 49
// bit periods. Period 0 raises sync with data low, periods 1..48 carry
// notes 0..47 with sync low. The vector is captured as the frame starts
// so one frame never mixes two detector states
module note_serializer
    import note_pkg::*;
(
    input  logic        clk_65mhz,
    input  logic        rst,
    input  active_vec_t active,            // Live detector flags
    output logic        note_serial_sync,
    output logic        note_serial_data
);

    localparam int CYC_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

    ser_state_t  state;
    logic [CYC_W-1:0] cyc_cnt;  // Clocks within a bit period
    note_idx_t   bit_cnt;       // Data period index, 0..47
    active_vec_t snap;          // Shifts out LSB first
    logic        period_end;

    assign period_end = (cyc_cnt == CYC_W'(BIT_CYCLES - 1));

    //////////////////////////////
    // Frame FSM
    always_ff @(posedge clk_65mhz) begin
        if (rst) begin
            state   <= SER_SYNC;  // Frame starts right after reset
            cyc_cnt <= '0;
            bit_cnt <= '0;
            snap    <= '0;        // Flags are all clear in reset
        end else if (period_end) begin
            cyc_cnt <= '0;
            case (state)
                SER_SYNC: begin
                    state   <= SER_DATA;
                    bit_cnt <= '0;
                end
                SER_DATA: begin
                    if (bit_cnt == note_idx_t'(NUM_NOTES - 1)) begin
                        state <= SER_SYNC;
                        snap  <= active;  // Capture for the next frame
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        snap    <= snap >> 1;  // Next note to bit 0
                    end
                end
                default: state <= SER_SYNC;
            endcase
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // Pins follow the state directly
    assign note_serial_sync = (state == SER_SYNC);
    assign note_serial_data = (state == SER_DATA) & snap[0];

endmodule

//--- hdl/guitar_note_top.sv
// Guitar note detection back end, top level
// Front panel conditioning feeds the per-note hysteresis detectors,
// whose active flags go out on a two pin serial link and on a parallel
// port. The selected note's thresholds are shown on the readout port
module guitar_note_top
    import note_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = DEBOUNCE_DEFAULT  // Button settle time
) (
    input  logic         clk_65mhz,
    input  logic         rst,
    input  logic         btn_up,              // Raw buttons
    input  logic         btn_down,
    input  note_idx_t    sw_note,             // Raw switches
    input  logic         sw_thresh_sel,
    input  corr_vec_t    correlations,        // Per note scores
    input  logic         correlations_valid,  // Single cycle strobe
    output active_vec_t  active,
    output thresh_pair_t sel_thresh,          // Selected note's pair
    output logic         note_serial_sync,
    output logic         note_serial_data
);

    panel_ctrl_t panel_ctrl;

    //////////////////////////////
    // Input side
    panel_input #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_panel_input (
        .clk_65mhz     (clk_65mhz),
        .rst           (rst),
        .btn_up        (btn_up),
        .btn_down      (btn_down),
        .sw_note       (sw_note),
        .sw_thresh_sel (sw_thresh_sel),
        .ctrl          (panel_ctrl)
    );

    //////////////////////////////
    // Detection
    note_detector_bank i_note_detector_bank (
        .clk_65mhz          (clk_65mhz),
        .rst                (rst),
        .ctrl               (panel_ctrl),
        .correlations       (correlations),
        .correlations_valid (correlations_valid),
        .active             (active),
        .sel_thresh         (sel_thresh)
    );

    //////////////////////////////
    // Serial output, reads the same flags as the parallel port
    note_serializer i_note_serializer (
        .clk_65mhz        (clk_65mhz),
        .rst              (rst),
        .active           (active),
        .note_serial_sync (note_serial_sync),
        .note_serial_data (note_serial_data)
    );

endmodule

//--- sim/tb_guitar_note_top.sv
// Testbench for the guitar note detection back end
// Drives score vectors, buttons and switches, keeps a model of every
// note's threshold pair and active flag, and checks the parallel flags,
// the threshold readout and the serial frame
module tb_guitar_note_top
    import note_pkg::*;
();

    localparam int DEBOUNCE_CYCLES = 16;   // Short debounce for simulation
    localparam int SETTLE_CYCLES   = 40;   // Quiet time after a release
    localparam int MAX_BOUNCES     = 8;
    localparam int MAX_BOUNCE_LEN  = 10;   // Well under the debounce time
    localparam int PRESS_CYCLES    = MAX_BOUNCES * MAX_BOUNCE_LEN + 6 * DEBOUNCE_CYCLES
                                     + SETTLE_CYCLES + 8;
    localparam int NUM_PRESSES     = 150;  // Upper bound over all tests
    localparam int FRAME_CYCLES    = (NUM_NOTES + 1) * BIT_CYCLES;
    localparam int TIMEOUT_CYCLES  = NUM_PRESSES * PRESS_CYCLES + 10 * FRAME_CYCLES + 22000;

    logic         clk_65mhz = 1'b0;
    logic         rst;
    logic         btn_up, btn_down;
    note_idx_t    sw_note;
    logic         sw_thresh_sel;
    corr_vec_t    correlations;
    logic         correlations_valid;
    active_vec_t  active;
    thresh_pair_t sel_thresh;
    logic         note_serial_sync, note_serial_data;

    thresh_pair_t model_pairs [NUM_NOTES];  // Expected thresholds per note
    active_vec_t  exp_active;               // Expected flags
    logic         valid_seen = 1'b0;        // Strobe taken on the last edge
    int           cycle_cnt = 0;

    guitar_note_top #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_dut (
        .clk_65mhz          (clk_65mhz),
        .rst                (rst),
        .btn_up             (btn_up),
        .btn_down           (btn_down),
        .sw_note            (sw_note),
        .sw_thresh_sel      (sw_thresh_sel),
        .correlations       (correlations),
        .correlations_valid (correlations_valid),
        .active             (active),
        .sel_thresh         (sel_thresh),
        .note_serial_sync   (note_serial_sync),
        .note_serial_data   (note_serial_data)
    );

    always #50 clk_65mhz = ~clk_65mhz;  // Period 100

    //////////////////////////////
    // Reference model
    // Hysteresis on every note against the model thresholds
    function automatic active_vec_t ref_active(input corr_vec_t scores, input active_vec_t prev);
        active_vec_t next;
        next = prev;
        for (int n = 0; n < NUM_NOTES; n++) begin
            if (scores[n] >= model_pairs[n].high) begin
                next[n] = 1'b1;
            end else if (scores[n] < model_pairs[n].low) begin
                next[n] = 1'b0;
            end
        end
        return next;
    endfunction

    function automatic correlation_t ref_step(input correlation_t value, input logic up);
        int result;
        result = up ? int'(value) + THRESH_STEP : int'(value) - THRESH_STEP;
        if (result > (1 << CORR_W) - 1) result = (1 << CORR_W) - 1;  // Top rail
        if (result < 0) result = 0;
        return correlation_t'(result);
    endfunction

    function automatic thresh_pair_t ref_readout(input note_idx_t note);
        if (note < NUM_NOTES) return model_pairs[note];
        return '0;  // Unused index reads blank
    endfunction

    //////////////////////////////
    // Compare tasks
    task automatic check_active(input active_vec_t got, input active_vec_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s, active %h expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "Active flag mismatch");
        end
    endtask

    task automatic check_thresh(input thresh_pair_t got, input thresh_pair_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s, high %h low %h expected high %h low %h",
                     $time, what, got.high, got.low, exp.high, exp.low);
            $display("Test failed");
            $fatal(1, "Threshold readout mismatch");
        end
    endtask

    task automatic check_serial(input logic sync, input logic data, input logic exp_sync,
                                input logic exp_data, input int period);
        if (sync !== exp_sync || data !== exp_data) begin
            $display("FAIL at %0t: period %0d, sync %b data %b expected sync %b data %b",
                     $time, period, sync, data, exp_sync, exp_data);
            $display("Test failed");
            $fatal(1, "Serial frame mismatch");
        end
    endtask

    // Flags settle on the edge that takes the strobe, checked half a cycle later
    always @(posedge clk_65mhz) valid_seen <= correlations_valid && !rst;

    always @(negedge clk_65mhz) begin
        if (valid_seen) begin
            check_active(active, exp_active, "after score strobe");
        end
    end

    always @(posedge clk_65mhz) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Test failed");
            $fatal(1, "Timeout after %0d cycles, the tests did not finish", cycle_cnt);
        end
    end

    //////////////////////////////
    // Stimulus helpers, all return on a falling edge
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_65mhz);
    endtask

    task automatic select_note(input note_idx_t note, input logic high_sel);
        sw_note       = note;
        sw_thresh_sel = high_sel;
        wait_cycles(3);  // Two sync stages plus margin
    endtask

    task automatic drive_button(input logic up, input logic level);
        if (up) begin
            btn_up = level;
        end else begin
            btn_down = level;
        end
    endtask

    // Optional bounce, a long hold, then release and settle
    task automatic press_and_check(input logic up, input logic bounce);
        logic level;
        int   toggles;
        level   = 1'b0;
        toggles = bounce ? 2 * (2 + int'($urandom % 3)) : 0;
        for (int i = 0; i < toggles; i++) begin
            level = ~level;
            drive_button(up, level);
            wait_cycles(1 + int'($urandom % MAX_BOUNCE_LEN));
        end
        drive_button(up, 1'b1);
        wait_cycles(4 * DEBOUNCE_CYCLES);  // Holding must not repeat the step
        drive_button(up, 1'b0);
        wait_cycles(2 * DEBOUNCE_CYCLES + SETTLE_CYCLES);
        if (sw_note < NUM_NOTES) begin
            if (sw_thresh_sel) begin
                model_pairs[sw_note].high = ref_step(model_pairs[sw_note].high, up);
            end else begin
                model_pairs[sw_note].low = ref_step(model_pairs[sw_note].low, up);
            end
        end
        check_thresh(sel_thresh, ref_readout(sw_note), "after press");
    endtask

    // One strobe, then junk on the bus which must be ignored
    task automatic apply_scores(input corr_vec_t scores);
        correlations       = scores;
        correlations_valid = 1'b1;
        exp_active         = ref_active(scores, exp_active);
        wait_cycles(1);
        correlations_valid = 1'b0;
        for (int n = 0; n < NUM_NOTES; n++) correlations[n] = correlation_t'($urandom);
        wait_cycles(1);
    endtask

    task automatic run_scores(input int count);
        corr_vec_t scores;
        for (int i = 0; i < count; i++) begin
            for (int n = 0; n < NUM_NOTES; n++) begin
                case ($urandom % 5)
                    0: scores[n] = model_pairs[n].high;         // Exactly at high
                    1: scores[n] = model_pairs[n].low - 1'b1;   // Just below low
                    2: scores[n] = model_pairs[n].low;          // Hold band edge
                    3: scores[n] = model_pairs[n].high - 1'b1;
                    default: scores[n] = correlation_t'($urandom);
                endcase
            end
            apply_scores(scores);
        end
    endtask

    // Lock onto a sync rise, then sample mid period through the frame
    task automatic check_frame();
        logic prev_sync;
        wait_cycles(FRAME_CYCLES + BIT_CYCLES);  // Flags stable for a whole frame
        do begin
            prev_sync = note_serial_sync;
            wait_cycles(1);
        end while (!(note_serial_sync && !prev_sync));
        wait_cycles(BIT_CYCLES / 2);
        for (int p = 0; p <= NUM_NOTES; p++) begin
            check_serial(note_serial_sync, note_serial_data, p == 0,
                         (p == 0) ? 1'b0 : exp_active[(p == 0) ? 0 : p - 1], p);
            wait_cycles(BIT_CYCLES);
        end
    endtask

    //////////////////////////////
    // Test sequence
    initial begin
        note_idx_t   note;
        active_vec_t pattern;
        corr_vec_t   scores;
        void'($urandom(32'h97d9_f37f));
        rst                = 1'b1;
        btn_up             = 1'b0;
        btn_down           = 1'b0;
        sw_note            = '0;
        sw_thresh_sel      = 1'b0;
        correlations       = '0;
        correlations_valid = 1'b0;
        exp_active         = '0;
        for (int n = 0; n < NUM_NOTES; n++) begin
            model_pairs[n] = '{high: THRESH_HIGH_DEFAULT, low: THRESH_LOW_DEFAULT};
        end
        wait_cycles(3);
        rst = 1'b0;

        // Reset values
        wait_cycles(1);
        check_active(active, '0, "after reset");
        for (int i = 0; i < 8; i++) begin
            select_note(note_idx_t'($urandom % NUM_NOTES), 1'($urandom));
            check_thresh(sel_thresh, ref_readout(sw_note), "default pair");
        end

        run_scores(40);  // Hysteresis on default thresholds

        // Bounced presses on one note, both directions
        note = note_idx_t'($urandom % NUM_NOTES);
        for (int i = 0; i < 4; i++) begin
            select_note(note, 1'($urandom));
            press_and_check(1'b1, 1'b1);
        end
        select_note(note, 1'b1);
        press_and_check(1'b0, 1'b1);
        run_scores(10);  // Hysteresis with the moved pair

        // Low threshold floor
        note = note_idx_t'($urandom % NUM_NOTES);
        select_note(note, 1'b0);
        for (int i = 0; i < 130; i++) press_and_check(1'b0, 1'b0);
        check_thresh(sel_thresh, '{high: model_pairs[note].high, low: '0}, "low floor");

        // Out of range select reaches no note
        select_note(note_idx_t'(50), 1'b1);
        press_and_check(1'b1, 1'b0);
        press_and_check(1'b0, 1'b0);
        select_note(note_idx_t'(50), 1'b0);
        press_and_check(1'b1, 1'b0);
        for (int n = 0; n < NUM_NOTES; n++) begin
            select_note(note_idx_t'(n), 1'b0);
            check_thresh(sel_thresh, model_pairs[n], "pair after out of range presses");
        end

        // Serial frames for two known vectors
        for (int k = 0; k < 2; k++) begin
            pattern = active_vec_t'({$urandom, $urandom});
            for (int n = 0; n < NUM_NOTES; n++) scores[n] = pattern[n] ? '1 : '0;
            apply_scores(scores);
            check_frame();
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- guitar_note_top.f
common/note_pkg.sv
hdl/button_conditioner.sv
hdl/panel_input.sv
detect/note_threshold.sv
detect/note_detector_bank.sv
hdl/note_serializer.sv
hdl/guitar_note_top.sv
sim/tb_guitar_note_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the guitar note testbench with Verilator and runs it
# A nonzero exit status means the build failed or the testbench stopped on an error

cd "$(dirname "$0")" || exit 1

TOP=tb_guitar_note_top
BUILD_DIR=obj_dir

verilator --binary --timing -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" \
    -f guitar_note_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

echo "Simulation exited cleanly"
exit 0
